/* Makefile */
TOP := ntt_frame_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f ntt_frame.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/frame_buffer.sv */
`timescale 1ns/10ps

module frame_buffer (
  input  logic                        axi_clk,
  input  ntt_frame_pkg::frame_state_t phase_i,
  input  ntt_frame_pkg::buf_req_t     load_req_i,
  input  ntt_frame_pkg::buf_req_t     unload_req_i,
  output ntt_frame_pkg::word_t        rdata_o
);

  ntt_frame_pkg::word_t    mem [ntt_frame_pkg::max_depth];
  ntt_frame_pkg::buf_req_t req;

  // Loader owns the port only while loading
  assign req = (phase_i == ntt_frame_pkg::load) ? load_req_i : unload_req_i;

  always_ff @(posedge axi_clk) begin
    if (req.en) begin
      if (req.we) begin
        mem[req.addr] <= req.wdata;
      end else begin
        rdata_o <= mem[req.addr];   // One-cycle read
      end
    end
  end

endmodule

/* design/frame_loader.sv */
`timescale 1ns/10ps

module frame_loader #(
  parameter int buf_depth = ntt_frame_pkg::max_depth
) (
  input  logic                        axi_clk,
  input  logic                        axi_reset_n,
  input  ntt_frame_pkg::frame_state_t phase_i,
  input  logic                        wide_i,
  input  logic                        ss_tvalid_i,
  input  ntt_frame_pkg::data_t        ss_tdata_i,
  output logic                        ss_tready_o,
  output ntt_frame_pkg::buf_req_t     req_o,
  output logic                        load_done_o
);

  ntt_frame_pkg::addr_t   word_cnt;
  ntt_frame_pkg::data_t   low_q;
  ntt_frame_pkg::sample_t sample;
  logic                   high_q;      // Low half is held
  logic                   active;
  logic                   beat;
  logic                   wr;

  assign active      = (phase_i == ntt_frame_pkg::load);
  assign ss_tready_o = active;
  assign beat        = ss_tvalid_i && ss_tready_o;
  assign wr          = beat && (!wide_i || high_q);
  assign sample      = ss_tdata_i[15:0];

  always_comb begin
    req_o.en    = wr;
    req_o.we    = wr;
    req_o.addr  = word_cnt;
    req_o.wdata = wide_i ? {ss_tdata_i, low_q} : {48'd0, sample};
  end

  assign load_done_o = wr && (word_cnt == ntt_frame_pkg::addr_t'(buf_depth - 1));

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      word_cnt <= '0;
      high_q   <= 1'b0;
    end else if (!active) begin
      word_cnt <= '0;
      high_q   <= 1'b0;
    end else begin
      if (beat && wide_i) high_q <= !high_q;
      if (wr) word_cnt <= word_cnt + 1'b1;
    end
  end

  // First beat of a wide pair
  always_ff @(posedge axi_clk) begin
    if (beat && !high_q) low_q <= ss_tdata_i;
  end

  // Load phase ends with the last word
  a_write_in_load: assert property (
    @(posedge axi_clk) disable iff (!axi_reset_n)
    load_done_o |=> !req_o.we
  );

endmodule

/* design/frame_unloader.sv */
`timescale 1ns/10ps

module frame_unloader #(
  parameter int buf_depth = ntt_frame_pkg::max_depth
) (
  input  logic                        axi_clk,
  input  logic                        axi_reset_n,
  input  ntt_frame_pkg::frame_state_t phase_i,
  input  logic                        wide_i,
  input  ntt_frame_pkg::word_t        rdata_i,
  output ntt_frame_pkg::buf_req_t     req_o,
  output logic                        sm_tvalid_o,
  output ntt_frame_pkg::data_t        sm_tdata_o,
  output logic                        sm_tlast_o,
  input  logic                        sm_tready_i,
  output logic                        unload_done_o
);

  localparam int cnt_w = $clog2(2 * buf_depth + 1);

  ntt_frame_pkg::word_t   store [2];   // Two-word prefetch store
  ntt_frame_pkg::word_t   head;
  ntt_frame_pkg::sample_t sample;
  ntt_frame_pkg::addr_t   rd_addr;
  logic [1:0]             fill;
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic                   rd_vld_q;    // Read data arrives this cycle
  logic                   rd_done;
  logic [cnt_w-1:0]       beat_cnt;
  logic                   half_q;      // High half of a wide word
  logic                   active;
  logic                   issue;
  logic                   take;
  logic                   pop;
  logic                   last;

  assign active = (phase_i == ntt_frame_pkg::unload);
  assign issue  = active && !rd_done && (({1'b0, fill} + rd_vld_q) < 3'd2);

  always_comb begin
    req_o.en    = issue;
    req_o.we    = 1'b0;
    req_o.addr  = rd_addr;
    req_o.wdata = '0;
  end

  assign head   = store[rd_ptr];
  assign sample = head[15:0];

  assign sm_tvalid_o = (fill != 2'd0);
  assign sm_tdata_o  = !wide_i ? {16'd0, sample} : (half_q ? head[63:32] : head[31:0]);
  assign last        = wide_i ? (beat_cnt == cnt_w'(2 * buf_depth - 1))
                              : (beat_cnt == cnt_w'(buf_depth - 1));
  assign sm_tlast_o  = sm_tvalid_o && last;

  assign take          = sm_tvalid_o && sm_tready_i;
  assign pop           = take && (!wide_i || half_q);
  assign unload_done_o = take && last;

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      rd_addr  <= '0;
      rd_done  <= 1'b0;
      rd_vld_q <= 1'b0;
      fill     <= 2'd0;
      wr_ptr   <= 1'b0;
      rd_ptr   <= 1'b0;
      beat_cnt <= '0;
      half_q   <= 1'b0;
    end else if (!active) begin
      rd_addr  <= '0;
      rd_done  <= 1'b0;
      rd_vld_q <= 1'b0;
      fill     <= 2'd0;
      wr_ptr   <= 1'b0;
      rd_ptr   <= 1'b0;
      beat_cnt <= '0;
      half_q   <= 1'b0;
    end else begin
      rd_vld_q <= issue;
      if (issue) begin
        rd_addr <= rd_addr + 1'b1;
        if (rd_addr == ntt_frame_pkg::addr_t'(buf_depth - 1)) rd_done <= 1'b1;
      end
      if (rd_vld_q) wr_ptr <= !wr_ptr;
      if (pop) rd_ptr <= !rd_ptr;
      fill <= fill + {1'b0, rd_vld_q} - {1'b0, pop};
      if (take) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (wide_i) half_q <= !half_q;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (rd_vld_q) store[wr_ptr] <= rdata_i;
  end

  a_hold_on_stall: assert property (
    @(posedge axi_clk) disable iff (!axi_reset_n)
    sm_tvalid_o && !sm_tready_i |=> sm_tvalid_o && $stable(sm_tdata_o) && $stable(sm_tlast_o)
  );

endmodule

/* design/ntt_frame_ctrl.sv */
`timescale 1ns/10ps

module ntt_frame_ctrl (
  input  logic                        axi_clk,
  input  logic                        axi_reset_n,
  input  logic                        ss_tvalid_i,
  input  ntt_frame_pkg::data_t        ss_tdata_i,
  input  logic                        load_done_i,
  input  logic                        unload_done_i,
  input  logic                        awvalid_i,
  input  ntt_frame_pkg::axil_addr_t   awaddr_i,
  input  logic                        wvalid_i,
  input  ntt_frame_pkg::data_t        wdata_i,
  output logic                        awready_o,
  output logic                        wready_o,
  input  logic                        arvalid_i,
  input  ntt_frame_pkg::axil_addr_t   araddr_i,
  output logic                        arready_o,
  output logic                        rvalid_o,
  output ntt_frame_pkg::data_t        rdata_o,
  input  logic                        rready_i,
  output logic                        cmd_ready_o,
  output ntt_frame_pkg::frame_state_t phase_o,
  output logic                        wide_o
);

  ntt_frame_pkg::frame_state_t state_q;
  ntt_frame_pkg::frame_state_t state_d;
  ntt_frame_pkg::axil_addr_t   rd_addr_q;
  logic                        wide_q;
  logic                        rvalid_q;
  logic                        cmd_beat;
  logic                        wr_fire;
  logic                        restart;
  logic                        status;

  assign cmd_ready_o = (state_q == ntt_frame_pkg::idle);
  assign cmd_beat    = cmd_ready_o && ss_tvalid_i
                       && (ss_tdata_i[3:2] == ntt_frame_pkg::cmd_op);

  // Address and data must arrive together
  assign wr_fire   = awvalid_i && wvalid_i;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;
  assign restart   = wr_fire && (awaddr_i == ntt_frame_pkg::status_addr) && wdata_i[0];

  always_comb begin
    state_d = state_q;
    case (state_q)
      ntt_frame_pkg::idle: begin
        if (cmd_beat) state_d = ntt_frame_pkg::load;   // Other beats are dropped
      end
      ntt_frame_pkg::load: begin
        if (load_done_i) state_d = ntt_frame_pkg::unload;
      end
      ntt_frame_pkg::unload: begin
        if (unload_done_i) state_d = ntt_frame_pkg::done;
      end
      ntt_frame_pkg::done: begin
        if (restart) state_d = ntt_frame_pkg::idle;
      end
      default: state_d = ntt_frame_pkg::idle;
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      state_q <= ntt_frame_pkg::idle;
      wide_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (cmd_beat) wide_q <= !ss_tdata_i[1];     // Modes 0 and 1 are wide
    end
  end

  assign phase_o = state_q;
  assign wide_o  = wide_q;

  // Later addresses are ignored until the response is taken
  assign arready_o = 1'b1;

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      rvalid_q <= 1'b0;
    end else if (rvalid_q) begin
      if (rready_i) rvalid_q <= 1'b0;
    end else if (arvalid_i) begin
      rvalid_q <= 1'b1;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!rvalid_q && arvalid_i) rd_addr_q <= araddr_i;
  end

  assign status   = (rd_addr_q == ntt_frame_pkg::status_addr)
                    && (state_q == ntt_frame_pkg::done);
  assign rvalid_o = rvalid_q;
  assign rdata_o  = ntt_frame_pkg::data_t'(status);

  a_rvalid_held: assert property (
    @(posedge axi_clk) disable iff (!axi_reset_n)
    rvalid_o && !rready_i |=> rvalid_o
  );

endmodule

/* design/ntt_frame_pkg.sv */
package ntt_frame_pkg;

  typedef logic [31:0] data_t;       // One stream beat
  typedef logic [63:0] word_t;       // One buffer word
  typedef logic [15:0] sample_t;     // Narrow sample
  typedef logic [9:0]  addr_t;
  typedef logic [11:0] axil_addr_t;

  localparam int unsigned max_depth = 1024;
  localparam logic [1:0] cmd_op = 2'b01;           // Command code in bits [3:2]
  localparam axil_addr_t status_addr = 12'h000;

  typedef enum logic [1:0] {
    idle   = 2'd0,
    load   = 2'd1,
    unload = 2'd2,
    done   = 2'd3
  } frame_state_t;

  // Loader and unloader share this request format
  typedef struct packed {
    logic  en;
    logic  we;
    addr_t addr;
    word_t wdata;
  } buf_req_t;

endpackage

/* design/ntt_frame_top.sv */
`timescale 1ns/10ps

module ntt_frame_top #(
  parameter int buf_depth = ntt_frame_pkg::max_depth
) (
  input  logic                      axi_clk,
  input  logic                      axi_reset_n,
  input  logic                      awvalid_i,
  input  ntt_frame_pkg::axil_addr_t awaddr_i,
  input  logic                      wvalid_i,
  input  ntt_frame_pkg::data_t      wdata_i,
  output logic                      awready_o,
  output logic                      wready_o,
  input  logic                      arvalid_i,
  input  ntt_frame_pkg::axil_addr_t araddr_i,
  output logic                      arready_o,
  output logic                      rvalid_o,
  output ntt_frame_pkg::data_t      rdata_o,
  input  logic                      rready_i,
  input  logic                      ss_tvalid_i,
  input  ntt_frame_pkg::data_t      ss_tdata_i,
  output logic                      ss_tready_o,
  output logic                      sm_tvalid_o,
  output ntt_frame_pkg::data_t      sm_tdata_o,
  output logic                      sm_tlast_o,
  input  logic                      sm_tready_i
);

  ntt_frame_pkg::frame_state_t phase;
  ntt_frame_pkg::buf_req_t     load_req;
  ntt_frame_pkg::buf_req_t     unload_req;
  ntt_frame_pkg::word_t        buf_rdata;
  logic                        wide;
  logic                        cmd_ready;
  logic                        load_ready;
  logic                        load_done;
  logic                        unload_done;

  assign ss_tready_o = cmd_ready | load_ready;   // Idle or loading

  ntt_frame_ctrl i_ctrl (
    .axi_clk       (axi_clk),
    .axi_reset_n   (axi_reset_n),
    .ss_tvalid_i   (ss_tvalid_i),
    .ss_tdata_i    (ss_tdata_i),
    .load_done_i   (load_done),
    .unload_done_i (unload_done),
    .awvalid_i     (awvalid_i),
    .awaddr_i      (awaddr_i),
    .wvalid_i      (wvalid_i),
    .wdata_i       (wdata_i),
    .awready_o     (awready_o),
    .wready_o      (wready_o),
    .arvalid_i     (arvalid_i),
    .araddr_i      (araddr_i),
    .arready_o     (arready_o),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .rready_i      (rready_i),
    .cmd_ready_o   (cmd_ready),
    .phase_o       (phase),
    .wide_o        (wide)
  );

  frame_loader #(.buf_depth(buf_depth)) i_loader (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .phase_i     (phase),
    .wide_i      (wide),
    .ss_tvalid_i (ss_tvalid_i),
    .ss_tdata_i  (ss_tdata_i),
    .ss_tready_o (load_ready),
    .req_o       (load_req),
    .load_done_o (load_done)
  );

  frame_unloader #(.buf_depth(buf_depth)) i_unloader (
    .axi_clk       (axi_clk),
    .axi_reset_n   (axi_reset_n),
    .phase_i       (phase),
    .wide_i        (wide),
    .rdata_i       (buf_rdata),
    .req_o         (unload_req),
    .sm_tvalid_o   (sm_tvalid_o),
    .sm_tdata_o    (sm_tdata_o),
    .sm_tlast_o    (sm_tlast_o),
    .sm_tready_i   (sm_tready_i),
    .unload_done_o (unload_done)
  );

  frame_buffer i_buffer (
    .axi_clk      (axi_clk),
    .phase_i      (phase),
    .load_req_i   (load_req),
    .unload_req_i (unload_req),
    .rdata_o      (buf_rdata)
  );

endmodule

/* ntt_frame.f */
design/ntt_frame_pkg.sv
design/ntt_frame_ctrl.sv
design/frame_loader.sv
design/frame_unloader.sv
design/frame_buffer.sv
design/ntt_frame_top.sv
sim/tb_clock_gen.sv
sim/ntt_frame_tb.sv

/* sim/ntt_frame_stim.txt */
// Entry = tag nibble, data word. Tags: 1 command, 2 input beat, 3 expected beat,
// 4 expected last beat, 5 status read with expected data, 6 status write, 0 end
5_00000000
1_00000005
2_10000001 2_20000002 2_30000003 2_40000004 2_50000005 2_60000006 2_70000007 2_80000008
3_10000001 3_20000002 3_30000003 3_40000004 3_50000005 3_60000006 3_70000007 4_80000008
5_00000001
6_00000001
5_00000000
1_00000006
2_dead1234 2_beef5678 2_cafe9abc 2_f00dffff
3_00001234 3_00005678 3_00009abc 4_0000ffff
5_00000001
6_00000001
2_00000008
5_00000000
1_00000004
2_0f0f0f0f 2_f0f0f0f0 2_12345678 2_9abcdef0 2_00000000 2_ffffffff 2_13572468 2_86427531
3_0f0f0f0f 3_f0f0f0f0 3_12345678 3_9abcdef0 3_00000000 3_ffffffff 3_13572468 4_86427531
5_00000001
0_00000000

/* sim/ntt_frame_tb.sv */
`timescale 1ns/10ps

module ntt_frame_tb;

  logic                      axi_clk;
  logic                      axi_reset_n;
  logic                      awvalid_i;
  ntt_frame_pkg::axil_addr_t awaddr_i;
  logic                      wvalid_i;
  ntt_frame_pkg::data_t      wdata_i;
  logic                      awready_o;
  logic                      wready_o;
  logic                      arvalid_i;
  ntt_frame_pkg::axil_addr_t araddr_i;
  logic                      arready_o;
  logic                      rvalid_o;
  ntt_frame_pkg::data_t      rdata_o;
  logic                      rready_i;
  logic                      ss_tvalid_i;
  ntt_frame_pkg::data_t      ss_tdata_i;
  logic                      ss_tready_o;
  logic                      sm_tvalid_o;
  ntt_frame_pkg::data_t      sm_tdata_o;
  logic                      sm_tlast_o;
  logic                      sm_tready_i;

  logic [35:0]               stim [64];   // Tag nibble over a data word
  logic [31:0]               rng;
  int                        errors;
  int                        checks;
  int                        cycles;
  int                        limit;
  logic                      expecting;   // An output beat is awaited
  logic                      stalled;
  ntt_frame_pkg::data_t      held_data;
  logic                      held_last;

  tb_clock_gen i_clock_gen (.clk_o(axi_clk), .reset_n_o(axi_reset_n));

  ntt_frame_top #(.buf_depth(4)) i_ntt_frame_top (.*);

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic send_beat(input ntt_frame_pkg::data_t data);
    ss_tvalid_i = 1'b1;
    ss_tdata_i  = data;
    @(negedge axi_clk);
    while (!ss_tready_o) @(negedge axi_clk);
    @(posedge axi_clk);
    #2;
    ss_tvalid_i = 1'b0;
  endtask

  task automatic expect_beat(input ntt_frame_pkg::data_t data, input logic last);
    expecting = 1'b1;
    @(negedge axi_clk);
    while (!(sm_tvalid_o && sm_tready_i)) @(negedge axi_clk);
    checks++;
    if (sm_tdata_o !== data) report_mismatch("sm_tdata_o", sm_tdata_o, data);
    if (sm_tlast_o !== last) report_mismatch("sm_tlast_o", {31'd0, sm_tlast_o}, {31'd0, last});
    @(posedge axi_clk);
    #2;
    expecting = 1'b0;
  endtask

  task automatic read_status(input ntt_frame_pkg::data_t exp);
    arvalid_i = 1'b1;
    araddr_i  = ntt_frame_pkg::status_addr;
    rready_i  = 1'b1;
    @(negedge axi_clk);
    checks++;
    if (arready_o !== 1'b1) report_mismatch("arready_o", {31'd0, arready_o}, 32'd1);
    @(posedge axi_clk);
    #2;
    arvalid_i = 1'b0;
    @(negedge axi_clk);
    while (!rvalid_o) @(negedge axi_clk);
    checks++;
    if (rdata_o !== exp) report_mismatch("rdata_o", rdata_o, exp);
    @(posedge axi_clk);
    #2;
    rready_i = 1'b0;
  endtask

  task automatic write_status(input ntt_frame_pkg::data_t data);
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    awaddr_i  = ntt_frame_pkg::status_addr;
    wdata_i   = data;
    @(negedge axi_clk);
    checks++;
    if (awready_o !== 1'b1) report_mismatch("awready_o", {31'd0, awready_o}, 32'd1);
    if (wready_o !== 1'b1) report_mismatch("wready_o", {31'd0, wready_o}, 32'd1);
    @(posedge axi_clk);
    #2;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
  endtask

  // Stall hold and stray beats
  always @(negedge axi_clk) begin
    if (axi_reset_n) begin
      if (stalled && !sm_tvalid_o) begin
        errors++;
        $display("sm_tvalid_o dropped during a stall at %0t ns", $time);
      end
      if (stalled && sm_tdata_o !== held_data) report_mismatch("sm_tdata_o", sm_tdata_o, held_data);
      if (stalled && sm_tlast_o !== held_last) begin
        report_mismatch("sm_tlast_o", {31'd0, sm_tlast_o}, {31'd0, held_last});
      end
      if (sm_tvalid_o && sm_tready_i && !expecting) begin
        errors++;
        $display("Output beat %h appeared with none expected at %0t ns", sm_tdata_o, $time);
      end
      stalled   = sm_tvalid_o && !sm_tready_i;
      held_data = sm_tdata_o;
      held_last = sm_tlast_o;
    end
  end

  always @(posedge axi_clk) begin
    #2;
    rng         = xorshift32(rng);
    sm_tready_i = rng[0];   // Random back-pressure
  end

  always @(posedge axi_clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int n;
    logic [3:0] tag;
    ntt_frame_pkg::data_t val;
    awvalid_i   = 1'b0;
    awaddr_i    = '0;
    wvalid_i    = 1'b0;
    wdata_i     = '0;
    arvalid_i   = 1'b0;
    araddr_i    = '0;
    rready_i    = 1'b0;
    ss_tvalid_i = 1'b0;
    ss_tdata_i  = '0;
    sm_tready_i = 1'b0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    expecting   = 1'b0;
    stalled     = 1'b0;
    held_data   = '0;
    held_last   = 1'b0;
    rng         = 32'd42;
    n           = 0;
    $readmemh("sim/ntt_frame_stim.txt", stim);
    while (n < 64 && stim[n][35:32] != 4'h0) n++;
    limit = 20 * n;
    if (n == 0) begin
      errors++;
      $display("The stim file holds no entries");
    end
    @(posedge axi_reset_n);
    @(posedge axi_clk);
    #2;
    checks++;
    if (ss_tready_o !== 1'b1) report_mismatch("ss_tready_o", {31'd0, ss_tready_o}, 32'd1);
    if (awready_o !== 1'b0) report_mismatch("awready_o", {31'd0, awready_o}, 32'd0);
    if (wready_o !== 1'b0) report_mismatch("wready_o", {31'd0, wready_o}, 32'd0);
    if (rvalid_o !== 1'b0) report_mismatch("rvalid_o", {31'd0, rvalid_o}, 32'd0);
    if (sm_tvalid_o !== 1'b0) report_mismatch("sm_tvalid_o", {31'd0, sm_tvalid_o}, 32'd0);
    if (sm_tlast_o !== 1'b0) report_mismatch("sm_tlast_o", {31'd0, sm_tlast_o}, 32'd0);
    for (int i = 0; i < n; i++) begin
      tag = stim[i][35:32];
      val = stim[i][31:0];
      case (tag)
        4'h1, 4'h2: send_beat(val);
        4'h3: expect_beat(val, 1'b0);
        4'h4: expect_beat(val, 1'b1);
        4'h5: read_status(val);
        4'h6: write_status(val);
        default: begin
          errors++;
          $display("Stim entry %0d has an unknown tag %h", i, tag);
        end
      endcase
    end
    repeat (4) @(posedge axi_clk);   // Catch stray output
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_n_o
);

  localparam int half_period  = 10;   // 20 ns clock
  localparam int reset_cycles = 8;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = !clk_o;
  end

  initial begin
    reset_n_o = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #2;
    reset_n_o = 1'b1;   // Release just after an edge
  end

endmodule
